// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cosim_top
OBJ_DIR   ?= obj_dir
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Finished with no errors

SOURCES := $(wildcard design/*.sv) $(wildcard testbench/*.sv) $(wildcard testbench/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# fails unless the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/addr_xlate.sv ====
`timescale 1ns/1ps

module addr_xlate
  import cosim_pkg::*;
#(
  parameter logic [CORE_ADDR_W-1:0] DRAM_LIMIT = 32'd125829120
)
(
  input  logic [HOST_ADDR_W-1:0] host_addr_i,
  output logic [CORE_ADDR_W-1:0] core_addr_o,
  input  logic [CORE_ADDR_W-1:0] dram_addr_i,
  input  logic [WORD_W-1:0]      dram_base_i,
  output logic [CORE_ADDR_W-1:0] dram_addr_o,
  output logic                   dram_range_err_o
);

  logic [CORE_ADDR_W-1:0] dram_off;

  // host window 0x0xxx_xxxx maps to core DRAM, 0x2xxx_xxxx to the low core space
  assign core_addr_o = {~host_addr_i[HOST_ADDR_W-1], 3'b000, host_addr_i[27:0]};

  // core DRAM offset rebased onto the buffer the host allocated
  assign dram_off         = dram_addr_i ^ DRAM_OFFSET;
  assign dram_addr_o      = dram_off + dram_base_i;
  assign dram_range_err_o = (dram_off >= DRAM_LIMIT);

endmodule

// ==== design/commit_capture.sv ====
`timescale 1ns/1ps

module commit_capture
  import cosim_pkg::*;
(
  input  logic          s01_axi_aclk,
  input  logic          rst_n_i,
  input  commit_probe_t probe_i,
  input  logic          full_i,
  output commit_rec_t   rec_o,
  output logic          rec_v_o,
  output logic          instret_o
);

  commit_probe_t probe_r;
  logic          trap_v;
  logic          rec_v;

  // one stage between the core and the trace path
  always_ff @(posedge s01_axi_aclk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      probe_r <= '0;
    end
    else
    begin
      probe_r <= probe_i;
    end
  end

  assign trap_v = probe_r.exception | probe_r.interrupt;
  assign rec_v  = probe_r.instret | trap_v;

  always_comb
  begin
    rec_o.debug   = probe_r.debug_mode;
    rec_o.instret = probe_r.instret;
    rec_o.trap    = trap_v;
    rec_o.pc      = probe_r.pc;
    rec_o.instr   = probe_r.instr;
    // write and request flags only mean something on a retired instruction
    rec_o.ird_w_v = probe_r.irf_w_v & probe_r.instret;
    rec_o.frd_w_v = probe_r.frf_w_v & probe_r.instret;
    rec_o.req_v   = probe_r.cache_req_v & probe_r.instret;
    rec_o.mstatus = probe_r.mstatus;
    if (probe_r.priv_m)
    begin
      rec_o.cause = probe_r.mcause;
      rec_o.epc   = probe_r.mepc;
    end
    else
    begin
      rec_o.cause = probe_r.scause;
      rec_o.epc   = probe_r.sepc;
    end
  end

  // record is lost when the buffer is full, the gate keeps this from happening
  assign rec_v_o   = rec_v & ~full_i;
  assign instret_o = probe_r.instret;

endmodule

// ==== design/cosim_pkg.sv ====
package cosim_pkg;

  localparam int VADDR_W     = 39;
  localparam int DWORD_W     = 64;
  localparam int WORD_W      = 32;
  localparam int INSTR_W     = 32;
  localparam int HOST_ADDR_W = 30;
  localparam int CORE_ADDR_W = 32;

  // core DRAM starts here, stripped by xor before adding the host base
  localparam logic [CORE_ADDR_W-1:0] DRAM_OFFSET = 32'h8000_0000;

  // what the core shows on its probe port in one cycle
  typedef struct packed {
    logic               instret;
    logic               exception;
    logic               interrupt;
    logic               debug_mode;
    logic [VADDR_W-1:0] pc;
    logic [INSTR_W-1:0] instr;
    logic               irf_w_v;
    logic               frf_w_v;
    logic               cache_req_v;
    logic               priv_m;
    logic [DWORD_W-1:0] mcause;
    logic [DWORD_W-1:0] scause;
    logic [VADDR_W-1:0] mepc;
    logic [VADDR_W-1:0] sepc;
    logic [DWORD_W-1:0] mstatus;
  } commit_probe_t;

  // one buffered commit record
  typedef struct packed {
    logic               debug;
    logic               instret;
    logic               trap;
    logic [VADDR_W-1:0] pc;
    logic [INSTR_W-1:0] instr;
    logic               ird_w_v;
    logic               frd_w_v;
    logic               req_v;
    logic [DWORD_W-1:0] cause;
    logic [VADDR_W-1:0] epc;
    logic [DWORD_W-1:0] mstatus;
  } commit_rec_t;

  typedef enum logic [1:0] {
    CSR_CTRL      = 2'd0,
    CSR_GATE_EN   = 2'd1,
    CSR_DRAM_BASE = 2'd2,
    CSR_STATUS    = 2'd3
  } csr_idx_e;

  // one state per trace word
  typedef enum logic [3:0] {
    IDLE,
    INSTR,
    META,
    PC_LO,
    PC_HI,
    MSTATUS_LO,
    MSTATUS_HI,
    CAUSE_LO,
    CAUSE_HI,
    EPC_LO,
    EPC_HI
  } trace_sel_e;

endpackage

// ==== design/cosim_top.sv ====
`timescale 1ns/1ps

module cosim_top
  import cosim_pkg::*;
#(
  parameter int                     FIFO_DEPTH    = 16,
  parameter int                     GATE_HEADROOM = 2,
  parameter logic [CORE_ADDR_W-1:0] DRAM_LIMIT    = 32'd125829120
)
(
  input  logic                   s01_axi_aclk,
  input  logic                   rst_n_i,
  input  commit_probe_t          probe_i,
  input  logic                   csr_we_i,
  input  csr_idx_e               csr_waddr_i,
  input  csr_idx_e               csr_raddr_i,
  input  logic [WORD_W-1:0]      csr_wdata_i,
  output logic [WORD_W-1:0]      csr_rdata_o,
  output logic [WORD_W-1:0]      trace_word_o,
  output logic                   trace_v_o,
  input  logic                   trace_ready_i,
  output logic                   gate_o,
  output logic                   core_reset_o,
  input  logic [HOST_ADDR_W-1:0] host_addr_i,
  output logic [CORE_ADDR_W-1:0] core_addr_o,
  input  logic [CORE_ADDR_W-1:0] dram_addr_i,
  output logic [CORE_ADDR_W-1:0] dram_addr_o,
  output logic                   dram_range_err_o
);

  localparam int FREE_W = $clog2(FIFO_DEPTH) + 1;

  commit_rec_t       cap_rec;
  logic              cap_rec_v;
  logic              instret_pulse;
  commit_rec_t       head_rec;
  logic              head_v;
  logic              head_pop;
  logic              fifo_full;
  logic [FREE_W-1:0] fifo_free;
  logic [WORD_W-1:0] dram_base;

  commit_capture u_capture (
    .s01_axi_aclk (s01_axi_aclk),
    .rst_n_i      (rst_n_i),
    .probe_i      (probe_i),
    .full_i       (fifo_full),
    .rec_o        (cap_rec),
    .rec_v_o      (cap_rec_v),
    .instret_o    (instret_pulse)
  );

  trace_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
    .s01_axi_aclk (s01_axi_aclk),
    .rst_n_i      (rst_n_i),
    .push_i       (cap_rec_v),
    .rec_i        (cap_rec),
    .pop_i        (head_pop),
    .rec_o        (head_rec),
    .rec_v_o      (head_v),
    .full_o       (fifo_full),
    .free_o       (fifo_free)
  );

  trace_serializer u_serializer (
    .s01_axi_aclk  (s01_axi_aclk),
    .rst_n_i       (rst_n_i),
    .rec_i         (head_rec),
    .rec_v_i       (head_v),
    .pop_o         (head_pop),
    .trace_word_o  (trace_word_o),
    .trace_v_o     (trace_v_o),
    .trace_ready_i (trace_ready_i)
  );

  host_csr #(.FIFO_DEPTH(FIFO_DEPTH), .GATE_HEADROOM(GATE_HEADROOM)) u_csr (
    .s01_axi_aclk (s01_axi_aclk),
    .rst_n_i      (rst_n_i),
    .csr_we_i     (csr_we_i),
    .csr_waddr_i  (csr_waddr_i),
    .csr_wdata_i  (csr_wdata_i),
    .csr_raddr_i  (csr_raddr_i),
    .csr_rdata_o  (csr_rdata_o),
    .free_i       (fifo_free),
    .instret_i    (instret_pulse),
    .dram_base_o  (dram_base),
    .core_reset_o (core_reset_o),
    .gate_o       (gate_o)
  );

  addr_xlate #(.DRAM_LIMIT(DRAM_LIMIT)) u_xlate (
    .host_addr_i      (host_addr_i),
    .core_addr_o      (core_addr_o),
    .dram_addr_i      (dram_addr_i),
    .dram_base_i      (dram_base),
    .dram_addr_o      (dram_addr_o),
    .dram_range_err_o (dram_range_err_o)
  );

endmodule

// ==== design/host_csr.sv ====
`timescale 1ns/1ps

module host_csr
  import cosim_pkg::*;
#(
  parameter int FIFO_DEPTH    = 16,
  parameter int GATE_HEADROOM = 2
)
(
  input  logic                        s01_axi_aclk,
  input  logic                        rst_n_i,
  input  logic                        csr_we_i,
  input  csr_idx_e                    csr_waddr_i,
  input  logic [WORD_W-1:0]           csr_wdata_i,
  input  csr_idx_e                    csr_raddr_i,
  output logic [WORD_W-1:0]           csr_rdata_o,
  input  logic [$clog2(FIFO_DEPTH):0] free_i,
  input  logic                        instret_i,
  output logic [WORD_W-1:0]           dram_base_o,
  output logic                        core_reset_o,
  output logic                        gate_o
);

  localparam int FREE_W = $clog2(FIFO_DEPTH) + 1;
  localparam logic [FREE_W-1:0] EMPTY_FREE = FREE_W'(FIFO_DEPTH);
  localparam logic [FREE_W-1:0] HEADROOM   = FREE_W'(GATE_HEADROOM);

  logic [WORD_W-1:0] ctrl_r;
  logic [WORD_W-1:0] gate_en_r;
  logic [WORD_W-1:0] dram_base_r;
  logic [WORD_W-2:0] instret_cnt_r;
  logic              gate_r;

  always_ff @(posedge s01_axi_aclk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      ctrl_r      <= '0;
      gate_en_r   <= '0;
      dram_base_r <= '0;
    end
    else if (csr_we_i)
    begin
      // status is read only
      case (csr_waddr_i)
        CSR_CTRL:      ctrl_r      <= csr_wdata_i;
        CSR_GATE_EN:   gate_en_r   <= csr_wdata_i;
        CSR_DRAM_BASE: dram_base_r <= csr_wdata_i;
        default:       ;
      endcase
    end
  end

  always_ff @(posedge s01_axi_aclk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      instret_cnt_r <= '0;
    else if (core_reset_o)
      instret_cnt_r <= '0;
    else if (instret_i)
      instret_cnt_r <= instret_cnt_r + 1'b1;
  end

  // stall the core near full, release once the buffer has drained
  always_ff @(posedge s01_axi_aclk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      gate_r <= 1'b0;
    else if (!gate_r && (free_i <= HEADROOM) && gate_en_r[0])
      gate_r <= 1'b1;
    else if (gate_r && ((free_i == EMPTY_FREE) || !gate_en_r[0]))
      gate_r <= 1'b0;
  end

  always_comb
  begin
    case (csr_raddr_i)
      CSR_CTRL:      csr_rdata_o = ctrl_r;
      CSR_GATE_EN:   csr_rdata_o = gate_en_r;
      CSR_DRAM_BASE: csr_rdata_o = dram_base_r;
      default:       csr_rdata_o = {gate_r, instret_cnt_r};
    endcase
  end

  assign dram_base_o  = dram_base_r;
  assign core_reset_o = ~ctrl_r[0];
  assign gate_o       = gate_r;

endmodule

// ==== design/trace_fifo.sv ====
`timescale 1ns/1ps

module trace_fifo
  import cosim_pkg::*;
#(
  parameter int FIFO_DEPTH = 16
)
(
  input  logic                          s01_axi_aclk,
  input  logic                          rst_n_i,
  input  logic                          push_i,
  input  commit_rec_t                   rec_i,
  input  logic                          pop_i,
  output commit_rec_t                   rec_o,
  output logic                          rec_v_o,
  output logic                          full_o,
  output logic [$clog2(FIFO_DEPTH):0]   free_o
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam logic [PTR_W:0] DEPTH_CNT = (PTR_W+1)'(FIFO_DEPTH);

  commit_rec_t      mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_r;
  logic [PTR_W-1:0] rd_ptr_r;
  logic [PTR_W:0]   count_r;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (count_r == DEPTH_CNT);
  assign rec_v_o = (count_r != '0);
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & rec_v_o;

  always_ff @(posedge s01_axi_aclk)
  begin
    if (do_push)
    begin
      mem[wr_ptr_r] <= rec_i;
    end
  end

  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge s01_axi_aclk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr_r <= wr_ptr_r + 1'b1;
      if (do_pop)
        rd_ptr_r <= rd_ptr_r + 1'b1;
      if (do_push && !do_pop)
        count_r <= count_r + 1'b1;
      else if (!do_push && do_pop)
        count_r <= count_r - 1'b1;
    end
  end

  assign rec_o  = mem[rd_ptr_r];
  assign free_o = DEPTH_CNT - count_r;

endmodule

// ==== design/trace_serializer.sv ====
`timescale 1ns/1ps

module trace_serializer
  import cosim_pkg::*;
(
  input  logic              s01_axi_aclk,
  input  logic              rst_n_i,
  input  commit_rec_t       rec_i,
  input  logic              rec_v_i,
  output logic              pop_o,
  output logic [WORD_W-1:0] trace_word_o,
  output logic              trace_v_o,
  input  logic              trace_ready_i
);

  trace_sel_e         state_r;
  trace_sel_e         state_n;
  trace_sel_e         step_sel;
  commit_rec_t        cur_r;
  logic               xfer;
  logic [DWORD_W-1:0] pc_sx;
  logic [DWORD_W-1:0] epc_sx;
  logic [WORD_W-1:0]  meta;

  assign pop_o     = (state_r == IDLE) & rec_v_i;
  assign trace_v_o = (state_r != IDLE);
  assign xfer      = trace_v_o & trace_ready_i;

  always_ff @(posedge s01_axi_aclk)
  begin
    if (pop_o)
      cur_r <= rec_i;
  end

  // word that follows the current one
  always_comb
  begin
    unique case (state_r)
      INSTR:      step_sel = META;
      META:       step_sel = PC_LO;
      PC_LO:      step_sel = PC_HI;
      PC_HI:      step_sel = MSTATUS_LO;
      MSTATUS_LO: step_sel = MSTATUS_HI;
      MSTATUS_HI: step_sel = cur_r.trap ? CAUSE_LO : IDLE;
      CAUSE_LO:   step_sel = CAUSE_HI;
      CAUSE_HI:   step_sel = EPC_LO;
      EPC_LO:     step_sel = EPC_HI;
      default:    step_sel = IDLE;
    endcase
  end

  always_comb
  begin
    state_n = state_r;
    if (pop_o)
    begin
      // debug-mode records are dropped without output
      if (rec_i.debug)
        state_n = IDLE;
      else if (rec_i.instret)
        state_n = INSTR;
      else if (rec_i.trap)
        state_n = CAUSE_LO;
    end
    else if (xfer)
    begin
      state_n = step_sel;
    end
  end

  always_ff @(posedge s01_axi_aclk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      state_r <= IDLE;
    else
      state_r <= state_n;
  end

  assign pc_sx  = {{(DWORD_W-VADDR_W){cur_r.pc[VADDR_W-1]}}, cur_r.pc};
  assign epc_sx = {{(DWORD_W-VADDR_W){cur_r.epc[VADDR_W-1]}}, cur_r.epc};
  // rd field, then request and write flags
  assign meta   = {{(WORD_W-8){1'b0}}, cur_r.instr[11:7], cur_r.req_v,
                   cur_r.frd_w_v, cur_r.ird_w_v};

  always_comb
  begin
    unique case (state_r)
      INSTR:      trace_word_o = cur_r.instr;
      META:       trace_word_o = meta;
      PC_LO:      trace_word_o = pc_sx[WORD_W-1:0];
      PC_HI:      trace_word_o = pc_sx[DWORD_W-1:WORD_W];
      MSTATUS_LO: trace_word_o = cur_r.mstatus[WORD_W-1:0];
      MSTATUS_HI: trace_word_o = cur_r.mstatus[DWORD_W-1:WORD_W];
      CAUSE_LO:   trace_word_o = cur_r.cause[WORD_W-1:0];
      CAUSE_HI:   trace_word_o = cur_r.cause[DWORD_W-1:WORD_W];
      EPC_LO:     trace_word_o = epc_sx[WORD_W-1:0];
      EPC_HI:     trace_word_o = epc_sx[DWORD_W-1:WORD_W];
      default:    trace_word_o = '0;
    endcase
  end

endmodule

// ==== testbench/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// galois lfsr, x^32 + x^22 + x^2 + x + 1
logic [31:0] lfsr_q = 32'd46;

// words the trace stream should carry, oldest first
logic [31:0] exp_q[$];
int          n_expected = 0;

function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  if (s[0])
    return (s >> 1) ^ 32'h8020_0003;
  else
    return s >> 1;
endfunction

// one lfsr step per bit taken
task automatic take_bits(input int n, output logic [63:0] v);
  v = '0;
  for (int i = 0; i < n; i++)
  begin
    v[i] = lfsr_q[0];
    lfsr_q = lfsr_step(lfsr_q);
  end
endtask

task automatic expect_word(input logic [31:0] w);
  exp_q.push_back(w);
  n_expected++;
endtask

task automatic model_probe(input commit_probe_t p);
  logic [63:0] pc_sx;
  logic [63:0] epc_sx;
  logic [63:0] cause;
  logic [31:0] meta;
  pc_sx  = {{25{p.pc[38]}}, p.pc};
  epc_sx = p.priv_m ? {{25{p.mepc[38]}}, p.mepc} : {{25{p.sepc[38]}}, p.sepc};
  cause  = p.priv_m ? p.mcause : p.scause;
  meta   = {24'h0, p.instr[11:7], p.cache_req_v, p.frf_w_v, p.irf_w_v};
  // debug-mode records leave no trace words
  if (!p.debug_mode)
  begin
    if (p.instret)
    begin
      expect_word(p.instr);
      expect_word(meta);
      expect_word(pc_sx[31:0]);
      expect_word(pc_sx[63:32]);
      expect_word(p.mstatus[31:0]);
      expect_word(p.mstatus[63:32]);
    end
    if (p.exception || p.interrupt)
    begin
      expect_word(cause[31:0]);
      expect_word(cause[63:32]);
      expect_word(epc_sx[31:0]);
      expect_word(epc_sx[63:32]);
    end
  end
endtask

`endif

// ==== testbench/tb_cosim_top.sv ====
`timescale 1ns/1ps

module tb_cosim_top
  import cosim_pkg::*;
();

  localparam int CLK_PERIOD      = 10;
  localparam int RESET_CYCLES    = 16;
  localparam int N_PROBES        = 300;
  localparam int N_ADDR          = 200;
  localparam int GATE_TRY_LIMIT  = 40;
  localparam int DRAIN_LIMIT     = 500;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + 64 + N_PROBES * 20 + 2 * GATE_TRY_LIMIT
                                   + 3 * DRAIN_LIMIT + 2 * N_ADDR;
  localparam logic [31:0] DRAM_LIMIT_W = 32'(120 * 1024 * 1024);

  logic                   s01_axi_aclk;
  logic                   rst_n_i;
  commit_probe_t          probe_i;
  logic                   csr_we_i;
  csr_idx_e               csr_waddr_i;
  csr_idx_e               csr_raddr_i;
  logic [WORD_W-1:0]      csr_wdata_i;
  logic [WORD_W-1:0]      csr_rdata_o;
  logic [WORD_W-1:0]      trace_word_o;
  logic                   trace_v_o;
  logic                   trace_ready_i;
  logic                   gate_o;
  logic                   core_reset_o;
  logic [HOST_ADDR_W-1:0] host_addr_i;
  logic [CORE_ADDR_W-1:0] core_addr_o;
  logic [CORE_ADDR_W-1:0] dram_addr_i;
  logic [CORE_ADDR_W-1:0] dram_addr_o;
  logic                   dram_range_err_o;

  int          errors = 0;
  int          n_checks = 0;
  int          n_words = 0;
  int          n_instret = 0;
  logic [31:0] mon_word;

  `include "tb_model.svh"

  cosim_top #(
    .FIFO_DEPTH    (16),
    .GATE_HEADROOM (2),
    .DRAM_LIMIT    (DRAM_LIMIT_W)
  ) dut (
    .s01_axi_aclk     (s01_axi_aclk),
    .rst_n_i          (rst_n_i),
    .probe_i          (probe_i),
    .csr_we_i         (csr_we_i),
    .csr_waddr_i      (csr_waddr_i),
    .csr_raddr_i      (csr_raddr_i),
    .csr_wdata_i      (csr_wdata_i),
    .csr_rdata_o      (csr_rdata_o),
    .trace_word_o     (trace_word_o),
    .trace_v_o        (trace_v_o),
    .trace_ready_i    (trace_ready_i),
    .gate_o           (gate_o),
    .core_reset_o     (core_reset_o),
    .host_addr_i      (host_addr_i),
    .core_addr_o      (core_addr_o),
    .dram_addr_i      (dram_addr_i),
    .dram_addr_o      (dram_addr_o),
    .dram_range_err_o (dram_range_err_o)
  );

  initial
  begin
    s01_axi_aclk = 1'b0;
    forever #(CLK_PERIOD / 2) s01_axi_aclk = ~s01_axi_aclk;
  end

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    n_checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERR %0t: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic next_cycle();
    @(posedge s01_axi_aclk);
    #1;
  endtask

  task automatic csr_write(input csr_idx_e idx, input logic [31:0] data);
    csr_we_i    = 1'b1;
    csr_waddr_i = idx;
    csr_wdata_i = data;
    next_cycle();
    csr_we_i = 1'b0;
  endtask

  task automatic csr_read_check(input csr_idx_e idx, input logic [31:0] exp, input string what);
    csr_raddr_i = idx;
    #1;
    check(what, 64'(csr_rdata_o), 64'(exp));
  endtask

  task automatic random_probe(output commit_probe_t p);
    logic [63:0] r;
    p = '0;
    take_bits(2, r);
    p.instret = (r[1:0] != 2'b00);
    take_bits(3, r);
    p.exception = (r[2:0] == 3'b000);
    take_bits(4, r);
    p.interrupt = (r[3:0] == 4'b0000);
    take_bits(3, r);
    p.debug_mode = (r[2:0] == 3'b000);
    take_bits(39, r);
    p.pc = r[38:0];
    take_bits(32, r);
    p.instr = r[31:0];
    take_bits(4, r);
    p.irf_w_v     = r[0];
    p.frf_w_v     = r[1];
    p.cache_req_v = r[2];
    p.priv_m      = r[3];
    take_bits(64, r);
    p.mcause = r;
    take_bits(64, r);
    p.scause = r;
    take_bits(39, r);
    p.mepc = r[38:0];
    take_bits(39, r);
    p.sepc = r[38:0];
    take_bits(64, r);
    p.mstatus = r;
  endtask

  task automatic drive_probe(input commit_probe_t p);
    probe_i = p;
    model_probe(p);
    if (p.instret)
      n_instret++;
  endtask

  // done when every expected word has moved
  task automatic wait_drain(input string what);
    int cycles;
    cycles = 0;
    while ((exp_q.size() != 0 || trace_v_o) && cycles < DRAIN_LIMIT)
    begin
      next_cycle();
      cycles++;
    end
    if (exp_q.size() != 0 || trace_v_o)
    begin
      errors++;
      $display("%s: trace stream did not drain within %0d cycles", what, DRAIN_LIMIT);
    end
    repeat (4) next_cycle();
  endtask

  task automatic csr_test();
    logic [63:0] r;
    logic [31:0] ctrl;
    check("core_reset_o after reset", 64'(core_reset_o), 64'd1);
    check("gate_o after reset", 64'(gate_o), 64'd0);
    check("trace_v_o after reset", 64'(trace_v_o), 64'd0);
    csr_read_check(CSR_STATUS, 32'h0, "status after reset");
    take_bits(32, r);
    csr_write(CSR_GATE_EN, r[31:0]);
    csr_read_check(CSR_GATE_EN, r[31:0], "gate enable readback");
    take_bits(32, r);
    csr_write(CSR_DRAM_BASE, r[31:0]);
    csr_read_check(CSR_DRAM_BASE, r[31:0], "dram base readback");
    take_bits(32, r);
    ctrl = r[31:0];
    csr_write(CSR_CTRL, ctrl);
    csr_read_check(CSR_CTRL, ctrl, "ctrl readback");
    check("core_reset_o follows ctrl", 64'(core_reset_o), 64'(!ctrl[0]));
    csr_write(CSR_CTRL, 32'h0);
    check("core_reset_o held", 64'(core_reset_o), 64'd1);
    csr_write(CSR_CTRL, 32'h1);
    check("core_reset_o released", 64'(core_reset_o), 64'd0);
    csr_read_check(CSR_STATUS, 32'h0, "status before stream");
    csr_write(CSR_GATE_EN, 32'h1);
  endtask

  task automatic stream_test();
    commit_probe_t p;
    logic [63:0]   r;
    int            n_driven;
    n_driven = 0;
    while (n_driven < N_PROBES)
    begin
      take_bits(2, r);
      trace_ready_i = (r[1:0] != 2'b00);
      // the core is stalled while the gate is up
      if (gate_o)
        probe_i = '0;
      else
      begin
        random_probe(p);
        drive_probe(p);
        n_driven++;
      end
      next_cycle();
    end
    probe_i       = '0;
    trace_ready_i = 1'b1;
    wait_drain("random stream");
  endtask

  task automatic gate_test();
    commit_probe_t p;
    int            n;
    trace_ready_i = 1'b0;
    n = 0;
    while (!gate_o && n < GATE_TRY_LIMIT)
    begin
      random_probe(p);
      p.instret    = 1'b1;
      p.debug_mode = 1'b0;
      drive_probe(p);
      n++;
      next_cycle();
    end
    probe_i = '0;
    check("gate_o rises with stream stalled", 64'(gate_o), 64'd1);
    repeat (8)
    begin
      next_cycle();
      check("gate_o holds while stalled", 64'(gate_o), 64'd1);
    end
    trace_ready_i = 1'b1;
    wait_drain("gate release");
    check("gate_o falls after drain", 64'(gate_o), 64'd0);

    csr_write(CSR_GATE_EN, 32'h0);
    trace_ready_i = 1'b0;
    // enough records to bring the free count down to the headroom
    for (int i = 0; i < 15; i++)
    begin
      random_probe(p);
      p.instret    = 1'b1;
      p.debug_mode = 1'b0;
      drive_probe(p);
      next_cycle();
      check("gate_o low with gate disabled", 64'(gate_o), 64'd0);
    end
    probe_i = '0;
    repeat (4)
    begin
      next_cycle();
      check("gate_o low with gate disabled", 64'(gate_o), 64'd0);
    end
    trace_ready_i = 1'b1;
    wait_drain("gate disabled");
  endtask

  task automatic addr_test();
    logic [63:0] r;
    logic [31:0] base;
    logic [31:0] off;
    logic [31:0] exp_core;
    logic [31:0] exp_dram;
    logic        exp_err;
    take_bits(32, r);
    base = r[31:0];
    csr_write(CSR_DRAM_BASE, base);
    for (int i = 0; i < N_ADDR; i++)
    begin
      take_bits(30, r);
      host_addr_i = r[29:0];
      take_bits(1, r);
      if (r[0])
      begin
        // offsets on both sides of the window limit
        take_bits(27, r);
        dram_addr_i = {5'b10000, r[26:0]};
      end
      else
      begin
        take_bits(32, r);
        dram_addr_i = r[31:0];
      end
      #1;
      exp_core = {~host_addr_i[29], 3'b000, host_addr_i[27:0]};
      off      = dram_addr_i ^ 32'h8000_0000;
      exp_dram = off + base;
      exp_err  = (off >= DRAM_LIMIT_W);
      check("core_addr_o", 64'(core_addr_o), 64'(exp_core));
      check("dram_addr_o", 64'(dram_addr_o), 64'(exp_dram));
      check("dram_range_err_o", 64'(dram_range_err_o), 64'(exp_err));
      next_cycle();
    end
  endtask

  // a word moves on the rising edge after a cycle with valid and ready
  always @(negedge s01_axi_aclk)
  begin
    if (rst_n_i && trace_v_o && trace_ready_i)
    begin
      if (exp_q.size() == 0)
      begin
        errors++;
        $display("trace word %h at %0t arrived when no word was expected", trace_word_o, $time);
      end
      else
      begin
        mon_word = exp_q.pop_front();
        check("trace word", 64'(trace_word_o), 64'(mon_word));
        n_words++;
      end
    end
  end

  initial
  begin
    rst_n_i       = 1'b0;
    probe_i       = '0;
    csr_we_i      = 1'b0;
    csr_waddr_i   = CSR_CTRL;
    csr_raddr_i   = CSR_STATUS;
    csr_wdata_i   = '0;
    trace_ready_i = 1'b0;
    host_addr_i   = '0;
    dram_addr_i   = '0;
    repeat (RESET_CYCLES) @(posedge s01_axi_aclk);
    #1;
    rst_n_i = 1'b1;
    csr_test();
    stream_test();
    gate_test();
    csr_read_check(CSR_STATUS, {1'b0, n_instret[30:0]}, "status instret count");
    addr_test();
    check("trace words transferred", 64'(n_words), 64'(n_expected));
    $display("checks %0d, errors %0d, trace words %0d", n_checks, errors, n_words);
    if (errors == 0)
    begin
      $display("Finished with no errors");
    end
    else
    begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the test did not complete", WATCHDOG_CYCLES);
    $display("Finished with errors");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+testbench
design/cosim_pkg.sv
design/commit_capture.sv
design/trace_fifo.sv
design/trace_serializer.sv
design/host_csr.sv
design/addr_xlate.sv
design/cosim_top.sv
testbench/tb_cosim_top.sv
